// ==== sources.f ====
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
dv/tb_rv_core.sv

// ==== Makefile ====
# Verilator simulation of the RV32 core
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -F "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  import rv_pkg::*;

  localparam logic [31:0] START_PC = 32'h8000_0000;
  localparam logic [31:0] DBASE    = 32'h8000_1000;
  localparam logic [31:0] PRELOAD  = 32'h8081_f0f7; // sits at DBASE + 0x40
  localparam logic [31:0] EBREAK   = 32'h0010_0073;
  localparam int          RUN_LIMIT = 200;

  logic        clk = 1'b0;
  logic        arst_n;
  logic [31:0] inst;
  logic [31:0] pc;
  dmem_req_t   dmem_req;
  logic [31:0] dmem_rdata;
  logic        halted;

  logic [31:0] imem [128];
  logic [31:0] dmem [256];
  logic [31:0] mem_exp [256]; // expected data memory while the program is built
  logic [31:0] regv [32];     // expected register values
  logic [31:0] trace [128];   // expected pc sequence
  int          trace_len;
  int          trace_pos;
  bit          exp_we [128];
  bit          exp_re [128];
  logic [31:0] exp_addr [128];
  logic [31:0] exp_wdata [128];
  logic [3:0]  exp_mask [128];
  logic [31:0] cursor;
  logic [11:0] res_off;
  int          ebreak_idx;
  bit          stopped;
  logic [31:0] stop_pc;
  integer      seed = 32'h7072;

  rv_core UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst       (inst),
    .pc         (pc),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halted     (halted)
  );

  always #10 clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else report_failure($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  function automatic int word_index(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - START_PC;
    return int'(offset[8:2]);
  endfunction

  function automatic logic [31:0] lane_bits(input logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  function automatic logic [31:0] fill_word(input int i);
    logic [31:0] a;
    a = DBASE + 32'(4 * i);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
  endfunction

  // sign or zero extension of the addressed byte or half
  function automatic logic [31:0] extend_load(input logic [2:0] f3, input logic [31:0] word,
                                              input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*off +: 8];
    h = word[16*off[1] +: 16];
    case (f3)
      3'b000:  return {{24{b[7]}}, b};
      3'b001:  return {{16{h[15]}}, h};
      3'b100:  return {24'h00_0000, b};
      3'b101:  return {16'h0000, h};
      default: return word;
    endcase
  endfunction

  task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
    if (rd != 5'd0) begin
      regv[rd] = v;
    end
  endtask

  task automatic place(input logic [31:0] word);
    imem[word_index(cursor)] = word;
    trace[trace_len] = cursor;
    trace_len++;
    cursor = cursor + 32'd4;
  endtask

  task automatic skip_to(input logic [31:0] target);
    while (cursor != target) begin
      imem[word_index(cursor)] = EBREAK; // only hit if a jump goes wrong
      cursor = cursor + 32'd4;
    end
  endtask

  task automatic lui_to(input logic [4:0] rd, input logic [19:0] imm);
    set_reg(rd, {imm, 12'h000});
    place({imm, rd, 7'h37});
  endtask

  task automatic auipc_to(input logic [4:0] rd, input logic [19:0] imm);
    set_reg(rd, cursor + {imm, 12'h000});
    place({imm, rd, 7'h17});
  endtask

  task automatic addi_to(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    set_reg(rd, regv[rs1] + {{20{imm[11]}}, imm});
    place({imm, rs1, 3'b000, rd, 7'h13});
  endtask

  task automatic jal_to(input logic [4:0] rd, input logic [20:0] off);
    logic [31:0] target;
    target = cursor + {{11{off[20]}}, off};
    set_reg(rd, cursor + 32'd4);
    place({off[20], off[10:1], off[11], off[19:12], rd, 7'h6f});
    skip_to(target);
  endtask

  task automatic jalr_to(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] target;
    target = (regv[rs1] + {{20{imm[11]}}, imm}) & 32'hffff_fffe;
    set_reg(rd, cursor + 32'd4);
    place({imm, rs1, 3'b000, rd, 7'h67});
    skip_to(target);
  endtask

  // loads and stores all use x10 as base
  task automatic load_to(input logic [2:0] f3, input logic [4:0] rd, input logic [11:0] imm);
    logic [31:0] a;
    int          i;
    a = regv[10] + {{20{imm[11]}}, imm};
    i = word_index(cursor);
    exp_re[i]   = 1'b1;
    exp_addr[i] = a;
    set_reg(rd, extend_load(f3, mem_exp[a[9:2]], a[1:0]));
    place({imm, 5'd10, f3, rd, 7'h03});
  endtask

  task automatic store_from(input logic [2:0] f3, input logic [4:0] rs2, input logic [11:0] imm);
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  m;
    int          i;
    a = regv[10] + {{20{imm[11]}}, imm};
    case (f3)
      3'b000: begin
        m = 4'b0001 << a[1:0];
        d = {4{regv[rs2][7:0]}};
      end
      3'b001: begin
        m = 4'b0011 << {a[1], 1'b0};
        d = {2{regv[rs2][15:0]}};
      end
      default: begin
        m = 4'b1111;
        d = regv[rs2];
      end
    endcase
    i = word_index(cursor);
    exp_we[i]    = 1'b1;
    exp_addr[i]  = a;
    exp_mask[i]  = m;
    exp_wdata[i] = d & lane_bits(m);
    mem_exp[a[9:2]] = (mem_exp[a[9:2]] & ~lane_bits(m)) | (d & lane_bits(m));
    place({imm[11:5], rs2, 5'd10, f3, imm[4:0], 7'h23});
  endtask

  task automatic store_result(input logic [4:0] rs2);
    store_from(3'b010, rs2, res_off);
    res_off = res_off + 12'd4;
  endtask

  task automatic set_value(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12; // addi sign-extends the low part
    lui_to(rd, hi[19:0]);
    addi_to(rd, rd, v[11:0]);
  endtask

  task automatic build_program();
    logic [31:0] v;
    for (int i = 0; i < 256; i++) begin
      dmem[i]    = fill_word(i);
      mem_exp[i] = dmem[i];
    end
    dmem[16] = PRELOAD;
    mem_exp[16] = PRELOAD;
    for (int i = 0; i < 128; i++) begin
      imem[i]   = 32'h0;
      exp_we[i] = 1'b0;
      exp_re[i] = 1'b0;
    end
    for (int i = 0; i < 32; i++) begin
      regv[i] = 32'h0;
    end
    cursor    = START_PC;
    res_off   = 12'h100;
    trace_len = 0;
    lui_to(5'd10, 20'h80001); // data base
    store_result(5'd10);
    lui_to(5'd1, 20'h12345);
    store_result(5'd1);
    auipc_to(5'd2, 20'habcde);
    store_result(5'd2);
    addi_to(5'd3, 5'd1, 12'hffb);
    store_result(5'd3);
    addi_to(5'd4, 5'd0, 12'h7ff);
    store_result(5'd4);
    jal_to(5'd5, 21'd12);
    store_result(5'd5);
    auipc_to(5'd6, 20'h0);
    jalr_to(5'd7, 5'd6, 12'd13); // odd target
    store_result(5'd7);
    for (int o = 0; o < 4; o++) begin
      load_to(3'b000, 5'd8, 12'(12'h040 + o));
      store_result(5'd8);
      load_to(3'b100, 5'd8, 12'(12'h040 + o));
      store_result(5'd8);
      if (o % 2 == 0) begin
        load_to(3'b001, 5'd8, 12'(12'h040 + o));
        store_result(5'd8);
        load_to(3'b101, 5'd8, 12'(12'h040 + o));
        store_result(5'd8);
      end
      if (o == 0) begin
        load_to(3'b010, 5'd8, 12'h040);
        store_result(5'd8);
      end
    end
    for (int o = 0; o < 6; o++) begin
      v = $random(seed);
      set_value(5'd9, v);
      if (o < 4) begin
        store_from(3'b000, 5'd9, 12'(12'h0c0 + o));
        load_to(3'b010, 5'd11, 12'h0c0);
      end else begin
        store_from(3'b001, 5'd9, 12'(12'h0c4 + 2 * (o - 4)));
        load_to(3'b010, 5'd11, 12'h0c4);
      end
      store_result(5'd11);
    end
    ebreak_idx = word_index(cursor);
    place(EBREAK);
    imem[ebreak_idx + 1] = {7'h00, 5'd1, 5'd10, 3'b010, 5'h10, 7'h23}; // sw x1, 16(x10)
  endtask

  // instruction and data memory answers
  initial begin : drive_memories
    inst       = 32'h0;
    dmem_rdata = 32'h0;
    forever begin
      @(posedge clk);
      #1;
      inst = halted ? imem[word_index(pc + 32'd4)] : imem[word_index(pc)];
      #1;
      dmem_rdata = dmem[dmem_req.addr[9:2]];
    end
  end

  always @(posedge clk) begin
    if (arst_n && dmem_req.we) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_req.wmask[b]) begin
          dmem[dmem_req.addr[9:2]][8*b +: 8] = dmem_req.wdata[8*b +: 8];
        end
      end
    end
  end

  always @(posedge clk) begin : check_ports
    int idx;
    if (!arst_n) begin
      check_value("pc", pc, START_PC);
      check_value("halted", {31'h0, halted}, 32'h0);
      check_value("dmem_req.we", {31'h0, dmem_req.we}, 32'h0);
    end else if (stopped) begin
      check_value("halted", {31'h0, halted}, 32'h1);
      check_value("pc", pc, stop_pc); // frozen
      check_value("dmem_req.we", {31'h0, dmem_req.we}, 32'h0);
    end else begin
      idx = word_index(trace[trace_pos]);
      check_value("pc", pc, trace[trace_pos]);
      check_value("halted", {31'h0, halted}, 32'h0);
      check_value("dmem_req.we", {31'h0, dmem_req.we}, {31'h0, exp_we[idx]});
      check_value("dmem_req.re", {31'h0, dmem_req.re}, {31'h0, exp_re[idx]});
      if (exp_we[idx] || exp_re[idx]) begin
        check_value("dmem_req.addr", dmem_req.addr, exp_addr[idx]);
      end
      if (exp_we[idx]) begin
        check_value("dmem_req.wmask", {28'h0, dmem_req.wmask}, {28'h0, exp_mask[idx]});
        check_value("dmem_req.wdata", dmem_req.wdata & lane_bits(exp_mask[idx]),
                    exp_wdata[idx]);
      end
      if (idx == ebreak_idx) begin
        stopped = 1'b1;
        stop_pc = trace[trace_pos];
      end else begin
        trace_pos++;
      end
    end
  end

  initial begin
    int n;
    arst_n    = 1'b1;
    stopped   = 1'b0;
    trace_pos = 0;
    build_program();
    #1;
    arst_n = 1'b0; // asserted between edges
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    n = 0;
    while (!halted && n < RUN_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!halted) begin
      report_failure("timeout, the core never reached ebreak");
    end
    repeat (4) @(posedge clk); // halted cycles with the sw presented
    #1;
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire [rv_pkg::XLEN-1:0]  inst,
  output logic [rv_pkg::XLEN-1:0] pc,
  output rv_pkg::dmem_req_t       dmem_req,
  input  wire [rv_pkg::XLEN-1:0]  dmem_rdata,
  output logic                    halted
);

  import rv_pkg::*;

  dec_ctrl_t       ctrl;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] alu_out;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] wb_data;
  logic [XLEN-1:0] load_data;

  rv_fetch u_fetch (
    .clk     (clk),
    .arst_n  (arst_n),
    .next_pc (next_pc),
    .ebreak  (ctrl.is_ebreak),
    .pc      (pc),
    .halted  (halted)
  );

  rv_decoder u_decoder (
    .inst (inst),
    .ctrl (ctrl)
  );

  rv_regfile u_regfile (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (ctrl.reg_we && !halted), // retire nothing after ebreak
    .waddr  (ctrl.rd),
    .raddr1 (ctrl.rs1),
    .raddr2 (ctrl.rs2),
    .wdata  (wb_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  rv_execute u_execute (
    .ctrl      (ctrl),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .load_data (load_data),
    .alu_out   (alu_out),
    .next_pc   (next_pc),
    .wb_data   (wb_data)
  );

  rv_lsu u_lsu (
    .ctrl       (ctrl),
    .addr       (alu_out),
    .rs2_data   (rs2_data),
    .halted     (halted),
    .dmem_rdata (dmem_rdata),
    .dmem_req   (dmem_req),
    .load_data  (load_data)
  );

endmodule

`default_nettype wire

// ==== hdl/rv_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
  input  wire rv_pkg::dec_ctrl_t   ctrl,
  input  wire [rv_pkg::XLEN-1:0]   addr,
  input  wire [rv_pkg::XLEN-1:0]   rs2_data,
  input  wire                      halted,
  input  wire [rv_pkg::XLEN-1:0]   dmem_rdata,
  output rv_pkg::dmem_req_t        dmem_req,
  output logic [rv_pkg::XLEN-1:0]  load_data
);

  import rv_pkg::*;

  logic [1:0]      lane;
  logic [7:0]      rd_byte;
  logic [15:0]     rd_half;
  logic [3:0]      wmask;
  logic [XLEN-1:0] wdata;

  assign lane    = addr[1:0];
  assign rd_byte = dmem_rdata[{lane, 3'b000} +: 8];
  assign rd_half = dmem_rdata[{lane[1], 4'b0000} +: 16];

  // store side, misaligned sh/sw end up with an empty mask
  always_comb begin
    wmask = 4'b0000;
    wdata = '0;
    case (ctrl.funct3)
      F3_B: begin
        wmask = 4'b0001 << lane;
        wdata[{lane, 3'b000} +: 8] = rs2_data[7:0];
      end
      F3_H: begin
        if (!lane[0]) begin
          wmask = 4'b0011 << {lane[1], 1'b0};
          wdata[{lane[1], 4'b0000} +: 16] = rs2_data[15:0];
        end
      end
      F3_W: begin
        if (lane == 2'b00) begin
          wmask = 4'b1111;
          wdata = rs2_data;
        end
      end
      default: begin
      end
    endcase
  end

  // load side
  always_comb begin
    load_data = '0; // misaligned or unknown size reads as zero
    case (ctrl.funct3)
      F3_B:  load_data = {{24{rd_byte[7]}}, rd_byte};
      F3_BU: load_data = {24'h00_0000, rd_byte};
      F3_H: begin
        if (!lane[0]) begin
          load_data = {{16{rd_half[15]}}, rd_half};
        end
      end
      F3_HU: begin
        if (!lane[0]) begin
          load_data = {16'h0000, rd_half};
        end
      end
      F3_W: begin
        if (lane == 2'b00) begin
          load_data = dmem_rdata;
        end
      end
      default: begin
      end
    endcase
  end

  assign dmem_req = '{
    addr:  addr,
    wdata: wdata,
    wmask: wmask,
    we:    ctrl.is_store && !halted, // no stores once stopped
    re:    ctrl.is_load
  };

endmodule

`default_nettype wire

// ==== hdl/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire rv_pkg::dec_ctrl_t   ctrl,
  input  wire [rv_pkg::XLEN-1:0]   pc,
  input  wire [rv_pkg::XLEN-1:0]   rs1_data,
  input  wire [rv_pkg::XLEN-1:0]   load_data,
  output logic [rv_pkg::XLEN-1:0]  alu_out,
  output logic [rv_pkg::XLEN-1:0]  next_pc,
  output logic [rv_pkg::XLEN-1:0]  wb_data
);

  import rv_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] link;

  // one adder for addi, lui, auipc, jump targets and addresses
  assign op_a    = ctrl.a_is_pc ? pc : rs1_data;
  assign alu_out = op_a + ctrl.imm;

  assign link = pc + XLEN'(4);

  // jalr needs bit 0 cleared, jal target is even anyway
  assign next_pc = ctrl.is_jump ? {alu_out[XLEN-1:1], 1'b0} : link;

  always_comb begin
    case (ctrl.wb_sel)
      WB_LINK: wb_data = link;
      WB_LOAD: wb_data = load_data;
      default: wb_data = alu_out;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire                           clk,
  input  wire                           arst_n,
  input  wire                           we,
  input  wire [rv_pkg::REG_ADDR_W-1:0]  waddr,
  input  wire [rv_pkg::REG_ADDR_W-1:0]  raddr1,
  input  wire [rv_pkg::REG_ADDR_W-1:0]  raddr2,
  input  wire [rv_pkg::XLEN-1:0]        wdata,
  output logic [rv_pkg::XLEN-1:0]       rdata1,
  output logic [rv_pkg::XLEN-1:0]       rdata2
);

  import rv_pkg::*;

  logic [XLEN-1:0] regs [2**REG_ADDR_W];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // no bypass, a read in the write cycle sees the old value
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== hdl/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  wire [rv_pkg::XLEN-1:0] inst,
  output rv_pkg::dec_ctrl_t      ctrl
);

  import rv_pkg::*;

  opcode_e         opcode;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign opcode = opcode_e'(inst[6:0]);

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000}; // already shifted
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // defaults give a no-op that falls through to pc + 4
    ctrl        = '0;
    ctrl.rd     = inst[11:7];
    ctrl.rs1    = inst[19:15];
    ctrl.rs2    = inst[24:20];
    ctrl.imm    = imm_i;
    ctrl.funct3 = mem_f3_e'(inst[14:12]);
    ctrl.wb_sel = WB_ALU;

    case (opcode)
      OP_IMM: begin
        ctrl.reg_we = (inst[14:12] == 3'b000); // addi only
      end
      OP_LUI: begin
        ctrl.rs1    = '0; // x0 gives a zero operand, sum is the immediate
        ctrl.imm    = imm_u;
        ctrl.reg_we = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.a_is_pc = 1'b1;
        ctrl.imm     = imm_u;
        ctrl.reg_we  = 1'b1;
      end
      OP_JAL: begin
        ctrl.a_is_pc = 1'b1;
        ctrl.imm     = imm_j;
        ctrl.reg_we  = 1'b1;
        ctrl.is_jump = 1'b1;
        ctrl.wb_sel  = WB_LINK;
      end
      OP_JALR: begin
        ctrl.reg_we  = 1'b1;
        ctrl.is_jump = 1'b1;
        ctrl.wb_sel  = WB_LINK;
      end
      OP_LOAD: begin
        ctrl.reg_we  = 1'b1;
        ctrl.is_load = 1'b1;
        ctrl.wb_sel  = WB_LOAD;
      end
      OP_STORE: begin
        ctrl.imm      = imm_s;
        ctrl.is_store = 1'b1;
      end
      OP_SYSTEM: begin
        ctrl.is_ebreak = (inst == 32'h0010_0073); // ecall and csr ops fall through
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/rv_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire [rv_pkg::XLEN-1:0]  next_pc,
  input  wire                     ebreak,
  output logic [rv_pkg::XLEN-1:0] pc,
  output logic                    halted
);

  import rv_pkg::*;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else begin
      halted <= halted | ebreak; // sticky until reset
      // pc freezes on the ebreak itself
      if (!halted && !ebreak) begin
        pc <= next_pc;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

  // base opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b000_0011,
    OP_IMM    = 7'b001_0011,
    OP_AUIPC  = 7'b001_0111,
    OP_STORE  = 7'b010_0011,
    OP_LUI    = 7'b011_0111,
    OP_JALR   = 7'b110_0111,
    OP_JAL    = 7'b110_1111,
    OP_SYSTEM = 7'b111_0011
  } opcode_e;

  // access size for loads and stores
  typedef enum logic [2:0] {
    F3_B  = 3'b000,
    F3_H  = 3'b001,
    F3_W  = 3'b010,
    F3_BU = 3'b100,
    F3_HU = 3'b101
  } mem_f3_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LINK, // pc + 4
    WB_LOAD
  } wb_sel_e;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    mem_f3_e               funct3;
    logic                  a_is_pc; // adder takes pc instead of rs1
    logic                  reg_we;
    logic                  is_load;
    logic                  is_store;
    logic                  is_jump;
    wb_sel_e               wb_sel;
    logic                  is_ebreak;
  } dec_ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata; // already placed in its byte lanes
    logic [3:0]      wmask;
    logic            we;
    logic            re;
  } dmem_req_t;

endpackage

`default_nettype wire
